// File: common/vtc_config.svh
`ifndef VTC_CONFIG_SVH
`define VTC_CONFIG_SVH

// Field widths
`define VTC_SW_W            4
`define VTC_COORD_W         11
`define VTC_MODE_W          3

// Switch conditioning
`define VTC_SYNC_STAGES     2
`define VTC_DEBOUNCE_CYCLES 16   // Stable cycles before a code is taken

////////////////////////////////////////////////////////////////////////////
// Switch codes
////////////////////////////////////////////////////////////////////////////
`define VTC_SW_VGA          4'b0000
`define VTC_SW_SVGA         4'b0001
`define VTC_SW_XGA          4'b0011
`define VTC_SW_HD720        4'b0010
`define VTC_SW_SXGA         4'b1000
`define VTC_SW_CAMERA       4'b1001

////////////////////////////////////////////////////////////////////////////
// Per-format timing: active, front porch, sync width, back porch
////////////////////////////////////////////////////////////////////////////
// 640x480
`define VTC_VGA_HACT        11'd640
`define VTC_VGA_HFP         11'd16
`define VTC_VGA_HSW         11'd96
`define VTC_VGA_HBP         11'd48
`define VTC_VGA_VACT        11'd480
`define VTC_VGA_VFP         11'd11
`define VTC_VGA_VSW         11'd2
`define VTC_VGA_VBP         11'd31
`define VTC_VGA_NEG         1'b1
// 800x600
`define VTC_SVGA_HACT       11'd800
`define VTC_SVGA_HFP        11'd40
`define VTC_SVGA_HSW        11'd128
`define VTC_SVGA_HBP        11'd88
`define VTC_SVGA_VACT       11'd600
`define VTC_SVGA_VFP        11'd1
`define VTC_SVGA_VSW        11'd4
`define VTC_SVGA_VBP        11'd23
`define VTC_SVGA_NEG        1'b0
// 1024x768
`define VTC_XGA_HACT        11'd1024
`define VTC_XGA_HFP         11'd24
`define VTC_XGA_HSW         11'd136
`define VTC_XGA_HBP         11'd160
`define VTC_XGA_VACT        11'd768
`define VTC_XGA_VFP         11'd3
`define VTC_XGA_VSW         11'd6
`define VTC_XGA_VBP         11'd29
`define VTC_XGA_NEG         1'b1
// 1280x720
`define VTC_HD720_HACT      11'd1280
`define VTC_HD720_HFP       11'd110
`define VTC_HD720_HSW       11'd40
`define VTC_HD720_HBP       11'd220
`define VTC_HD720_VACT      11'd720
`define VTC_HD720_VFP       11'd5
`define VTC_HD720_VSW       11'd5
`define VTC_HD720_VBP       11'd20
`define VTC_HD720_NEG       1'b0
// 1280x1024
`define VTC_SXGA_HACT       11'd1280
`define VTC_SXGA_HFP        11'd48
`define VTC_SXGA_HSW        11'd112
`define VTC_SXGA_HBP        11'd248
`define VTC_SXGA_VACT       11'd1024
`define VTC_SXGA_VFP        11'd1
`define VTC_SXGA_VSW        11'd3
`define VTC_SXGA_VBP        11'd38
`define VTC_SXGA_NEG        1'b0
// Camera 720p, narrower syncs than HD720
`define VTC_CAMERA_HACT     11'd1280
`define VTC_CAMERA_HFP      11'd110
`define VTC_CAMERA_HSW      11'd39
`define VTC_CAMERA_HBP      11'd220
`define VTC_CAMERA_VACT     11'd720
`define VTC_CAMERA_VFP      11'd4
`define VTC_CAMERA_VSW      11'd4
`define VTC_CAMERA_VBP      11'd22
`define VTC_CAMERA_NEG      1'b0

`endif

// File: common/vtc_pkg.sv
`default_nettype none
`include "vtc_config.svh"

package vtc_pkg;

	// Raw code off the board switches
	typedef logic [`VTC_SW_W-1:0] sw_code_t;

	// Pixel or line count, also used for the counter bounds
	typedef logic [`VTC_COORD_W-1:0] coord_t;

	// Display formats
	typedef enum logic [`VTC_MODE_W-1:0] {
		MODE_VGA    = 3'd0,
		MODE_SVGA   = 3'd1,
		MODE_XGA    = 3'd2,
		MODE_HD720  = 3'd3, // Also the fallback for unknown codes
		MODE_SXGA   = 3'd4,
		MODE_CAMERA = 3'd5
	} video_mode_e;

endpackage

`default_nettype wire

// File: mode_ctrl/switch_conditioner.sv
`timescale 1ns/1ps
`default_nettype none
`include "vtc_config.svh"

module switch_conditioner
	import vtc_pkg::*;
(
	input  wire logic     clk50m_bufg,
	input  wire logic     RSTBTN,
	input  wire sw_code_t sw,          // Straight from the pins
	output sw_code_t      mode_code,   // Debounced, accepted code
	output logic          mode_change  // One cycle, on a settled change
);

localparam int unsigned CNT_W = $clog2(`VTC_DEBOUNCE_CYCLES + 1);
localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`VTC_DEBOUNCE_CYCLES - 1);

sw_code_t         sync_q [`VTC_SYNC_STAGES]; // Synchronizer chain, all four bits
sw_code_t         sw_sync;
sw_code_t         cand;                      // Code currently being timed
logic [CNT_W-1:0] stable_cnt;                // Cycles cand has been seen, minus one
logic             cand_match;
logic             cand_settled;

////////////////////////////////////////////////////////////////////////////
// Synchronizer
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN) begin
		for (int i = 0; i < `VTC_SYNC_STAGES; i++) begin
			sync_q[i] <= `VTC_SW_VGA;
		end
	end else begin
		sync_q[0] <= sw;
		for (int i = 1; i < `VTC_SYNC_STAGES; i++) begin
			sync_q[i] <= sync_q[i-1];
		end
	end
end

assign sw_sync = sync_q[`VTC_SYNC_STAGES-1];

////////////////////////////////////////////////////////////////////////////
// Debounce and change detect
////////////////////////////////////////////////////////////////////////////
assign cand_match   = (sw_sync == cand);
assign cand_settled = cand_match && (stable_cnt == CNT_LAST); // Last stable cycle

always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN) begin
		cand        <= `VTC_SW_VGA;
		stable_cnt  <= '0;
		mode_code   <= `VTC_SW_VGA;   // Power-up format
		mode_change <= 1'b0;
	end else begin
		mode_change <= 1'b0;
		if (!cand_match) begin
			// Fresh value, this cycle counts as the first
			cand       <= sw_sync;
			stable_cnt <= CNT_W'(1);
		end else if (stable_cnt != CNT_LAST) begin
			stable_cnt <= stable_cnt + 1'b1;
		end
		// Same code again gives no strobe
		if (cand_settled && (cand != mode_code)) begin
			mode_code   <= cand;
			mode_change <= 1'b1;
		end
	end
end

endmodule

`default_nettype wire

// File: mode_ctrl/mode_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "vtc_config.svh"

module mode_decoder
	import vtc_pkg::*;
(
	input  wire logic     clk50m_bufg,
	input  wire logic     RSTBTN,
	input  wire sw_code_t mode_code,
	input  wire logic     mode_change,
	output video_mode_e   active_mode,
	output logic          sync_negative, // 1 = active-low syncs
	output logic          restart,       // Raster restart, one cycle
	output coord_t        h_blank_start,
	output coord_t        h_sync_start,
	output coord_t        h_sync_end,
	output coord_t        h_total_last,
	output coord_t        v_blank_start,
	output coord_t        v_sync_start,
	output coord_t        v_sync_end,
	output coord_t        v_total_last
);

video_mode_e sel_mode;
logic        sel_neg;
coord_t      h_act, h_fp, h_sw, h_bp;
coord_t      v_act, v_fp, v_sw, v_bp;
coord_t      h_bs, h_ss, h_se, h_tl; // Running sums
coord_t      v_bs, v_ss, v_se, v_tl;

function automatic video_mode_e code_to_mode(input sw_code_t code);
	case (code)
		`VTC_SW_VGA:    return MODE_VGA;
		`VTC_SW_SVGA:   return MODE_SVGA;
		`VTC_SW_XGA:    return MODE_XGA;
		`VTC_SW_SXGA:   return MODE_SXGA;
		`VTC_SW_CAMERA: return MODE_CAMERA;
		default:        return MODE_HD720; // 720p code and anything unknown
	endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Format table
////////////////////////////////////////////////////////////////////////////
always_comb begin
	sel_mode = RSTBTN ? MODE_VGA : code_to_mode(mode_code); // VGA out of reset
	case (sel_mode)
		MODE_VGA: begin
			sel_neg = `VTC_VGA_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_VGA_HACT, `VTC_VGA_HFP, `VTC_VGA_HSW, `VTC_VGA_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_VGA_VACT, `VTC_VGA_VFP, `VTC_VGA_VSW, `VTC_VGA_VBP};
		end
		MODE_SVGA: begin
			sel_neg = `VTC_SVGA_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_SVGA_HACT, `VTC_SVGA_HFP, `VTC_SVGA_HSW,
				`VTC_SVGA_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_SVGA_VACT, `VTC_SVGA_VFP, `VTC_SVGA_VSW,
				`VTC_SVGA_VBP};
		end
		MODE_XGA: begin
			sel_neg = `VTC_XGA_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_XGA_HACT, `VTC_XGA_HFP, `VTC_XGA_HSW, `VTC_XGA_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_XGA_VACT, `VTC_XGA_VFP, `VTC_XGA_VSW, `VTC_XGA_VBP};
		end
		MODE_SXGA: begin
			sel_neg = `VTC_SXGA_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_SXGA_HACT, `VTC_SXGA_HFP, `VTC_SXGA_HSW,
				`VTC_SXGA_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_SXGA_VACT, `VTC_SXGA_VFP, `VTC_SXGA_VSW,
				`VTC_SXGA_VBP};
		end
		MODE_CAMERA: begin
			sel_neg = `VTC_CAMERA_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_CAMERA_HACT, `VTC_CAMERA_HFP, `VTC_CAMERA_HSW,
				`VTC_CAMERA_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_CAMERA_VACT, `VTC_CAMERA_VFP, `VTC_CAMERA_VSW,
				`VTC_CAMERA_VBP};
		end
		default: begin // MODE_HD720
			sel_neg = `VTC_HD720_NEG;
			{h_act, h_fp, h_sw, h_bp} = {`VTC_HD720_HACT, `VTC_HD720_HFP, `VTC_HD720_HSW,
				`VTC_HD720_HBP};
			{v_act, v_fp, v_sw, v_bp} = {`VTC_HD720_VACT, `VTC_HD720_VFP, `VTC_HD720_VSW,
				`VTC_HD720_VBP};
		end
	endcase
	// Each bound is the last count of its region
	h_bs = h_act - coord_t'(1);
	h_ss = h_bs + h_fp;
	h_se = h_ss + h_sw;
	h_tl = h_se + h_bp;
	v_bs = v_act - coord_t'(1);
	v_ss = v_bs + v_fp;
	v_se = v_ss + v_sw;
	v_tl = v_se + v_bp;
end

////////////////////////////////////////////////////////////////////////////
// Latched format
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN || mode_change) begin
		active_mode   <= sel_mode;
		sync_negative <= sel_neg;
		h_blank_start <= h_bs;
		h_sync_start  <= h_ss;
		h_sync_end    <= h_se;
		h_total_last  <= h_tl;
		v_blank_start <= v_bs;
		v_sync_start  <= v_ss;
		v_sync_end    <= v_se;
		v_total_last  <= v_tl;
	end
end

// Restart trails the new bounds by nothing, counters clear one cycle later
always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN) begin
		restart <= 1'b0;
	end else begin
		restart <= mode_change;
	end
end

endmodule

`default_nettype wire

// File: rtl/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing
	import vtc_pkg::*;
(
	input  wire logic   clk50m_bufg,
	input  wire logic   RSTBTN,
	input  wire logic   restart,       // Back to pixel 0, line 0
	input  wire logic   sync_negative,
	input  wire coord_t h_blank_start,
	input  wire coord_t h_sync_start,
	input  wire coord_t h_sync_end,
	input  wire coord_t h_total_last,
	input  wire coord_t v_blank_start,
	input  wire coord_t v_sync_start,
	input  wire coord_t v_sync_end,
	input  wire coord_t v_total_last,
	output coord_t      hcount,
	output coord_t      vcount,
	output logic        hsync,
	output logic        vsync,
	output logic        de
);

logic h_wrap;
logic h_blank, v_blank;
logic h_sync_int, v_sync_int;   // Active-high syncs, counter aligned
logic hsync_q, vsync_q, active_q; // First pipeline stage

////////////////////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////////////////////
assign h_wrap = (hcount >= h_total_last); // End of line

always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN || restart) begin
		hcount <= '0;
		vcount <= '0;
	end else if (h_wrap) begin
		hcount <= '0;
		if (vcount >= v_total_last) begin
			vcount <= '0;     // End of frame
		end else begin
			vcount <= vcount + 1'b1;
		end
	end else begin
		hcount <= hcount + 1'b1;
	end
end

// Blanking past the last active count, sync in (start, end]
assign h_blank    = (hcount > h_blank_start);
assign v_blank    = (vcount > v_blank_start);
assign h_sync_int = (hcount > h_sync_start) && (hcount <= h_sync_end);
assign v_sync_int = (vcount > v_sync_start) && (vcount <= v_sync_end);

////////////////////////////////////////////////////////////////////////////
// Two-stage output pipeline
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN) begin
		// Syncs parked at their idle level
		hsync_q  <= sync_negative;
		vsync_q  <= sync_negative;
		active_q <= 1'b0;
		hsync    <= sync_negative;
		vsync    <= sync_negative;
		de       <= 1'b0;
	end else begin
		hsync_q  <= h_sync_int ^ sync_negative; // Polarity fix
		vsync_q  <= v_sync_int ^ sync_negative;
		active_q <= !h_blank && !v_blank;
		hsync    <= hsync_q;
		vsync    <= vsync_q;
		de       <= active_q;
	end
end

endmodule

`default_nettype wire

// File: rtl/vtc_top.sv
`timescale 1ns/1ps
`default_nettype none

module vtc_top
	import vtc_pkg::*;
(
	input  wire logic     clk50m_bufg,
	input  wire logic     RSTBTN,     // Sync, active high
	input  wire sw_code_t sw,         // Async board switches
	output logic          hsync,
	output logic          vsync,
	output logic          de,
	output coord_t        hcount,
	output coord_t        vcount,
	output video_mode_e   active_mode
);

// Accepted switch code and its change strobe
sw_code_t mode_code;
logic     mode_change;

// Bounds and control from the format table
coord_t h_blank_start;
coord_t h_sync_start;
coord_t h_sync_end;
coord_t h_total_last;
coord_t v_blank_start;
coord_t v_sync_start;
coord_t v_sync_end;
coord_t v_total_last;
logic   sync_negative;
logic   restart;

switch_conditioner u_switch_conditioner (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.sw          (sw),
	.mode_code   (mode_code),
	.mode_change (mode_change)
);

mode_decoder u_mode_decoder (
	.clk50m_bufg   (clk50m_bufg),
	.RSTBTN        (RSTBTN),
	.mode_code     (mode_code),
	.mode_change   (mode_change),
	.active_mode   (active_mode),
	.sync_negative (sync_negative),
	.restart       (restart),
	.h_blank_start (h_blank_start),
	.h_sync_start  (h_sync_start),
	.h_sync_end    (h_sync_end),
	.h_total_last  (h_total_last),
	.v_blank_start (v_blank_start),
	.v_sync_start  (v_sync_start),
	.v_sync_end    (v_sync_end),
	.v_total_last  (v_total_last)
);

raster_timing u_raster_timing (
	.clk50m_bufg   (clk50m_bufg),
	.RSTBTN        (RSTBTN),
	.restart       (restart),
	.sync_negative (sync_negative),
	.h_blank_start (h_blank_start),
	.h_sync_start  (h_sync_start),
	.h_sync_end    (h_sync_end),
	.h_total_last  (h_total_last),
	.v_blank_start (v_blank_start),
	.v_sync_start  (v_sync_start),
	.v_sync_end    (v_sync_end),
	.v_total_last  (v_total_last),
	.hcount        (hcount),
	.vcount        (vcount),
	.hsync         (hsync),
	.vsync         (vsync),
	.de            (de)
);

endmodule

`default_nettype wire

// File: verif/vtc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vtc_properties
	import vtc_pkg::*;
(
	input wire logic   clk50m_bufg,
	input wire logic   RSTBTN,
	input wire logic   de,
	input wire logic   hsync,
	input wire logic   sync_negative,
	input wire logic   mode_change,
	input wire logic   restart,
	input wire coord_t hcount,
	input wire coord_t h_total_last
);

int   fail_count = 0; // Failed assertions so far
logic restart_q;
logic settled;

// Old polarity and bounds linger in the pipeline for two cycles after a switch
always_ff @(posedge clk50m_bufg) begin
	if (RSTBTN) begin
		restart_q <= 1'b0;
	end else begin
		restart_q <= restart;
	end
end

assign settled = !restart && !restart_q;

////////////////////////////////////////////////////////////////////////////
// Properties
////////////////////////////////////////////////////////////////////////////
a_de_outside_hsync: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	settled |-> !(de && (hsync != sync_negative)))
	else begin
		$error("de high while hsync is active");
		fail_count++;
	end

a_change_single: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	mode_change |=> !mode_change) // Strobe is one cycle wide
	else begin
		$error("mode_change high for two cycles");
		fail_count++;
	end

a_hcount_bound: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
	settled |-> (hcount <= h_total_last))
	else begin
		$error("hcount past h_total_last");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: verif/tb_vtc.sv
`timescale 1ns/1ps
`default_nettype none
`include "vtc_config.svh"

module tb_vtc
	import vtc_pkg::*;
();

typedef struct {
	string       name;
	sw_code_t    code;
	video_mode_e mode;
	int          h_total;
	int          h_sw;
	int          h_act;
	int          v_total;
	int          v_act;
	logic        neg;    // Idle level of both syncs
	bit          vert;   // Also measure a whole frame
} entry_t;

logic        clk50m_bufg = 1'b0;
logic        RSTBTN;
sw_code_t    sw;
logic        hsync;
logic        vsync;
logic        de;
coord_t      hcount;
coord_t      vcount;
video_mode_e active_mode;

entry_t      tbl [8];
int          errors = 0;
int          passed = 0;
int          failed = 0;
int unsigned cycles = 0;
int unsigned limit  = 32'hffff_ffff;
logic [31:0] lfsr_state = 32'hbfdf5419;

vtc_top u_vtc_top (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.sw          (sw),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de),
	.hcount      (hcount),
	.vcount      (vcount),
	.active_mode (active_mode)
);

bind vtc_top vtc_properties u_props (
	.clk50m_bufg   (clk50m_bufg),
	.RSTBTN        (RSTBTN),
	.de            (de),
	.hsync         (hsync),
	.sync_negative (sync_negative),
	.mode_change   (mode_change),
	.restart       (restart),
	.hcount        (hcount),
	.h_total_last  (h_total_last)
);

always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

// Watchdog
always @(posedge clk50m_bufg) begin
	cycles <= cycles + 1;
	if (cycles >= limit) begin
		$display("run stopped after %0d cycles, the DUT never reached the awaited state", cycles);
		$display("Test failed");
		$finish;
	end
end

////////////////////////////////////////////////////////////////////////////
// Table and helpers
////////////////////////////////////////////////////////////////////////////
function automatic entry_t make_entry(string name, sw_code_t code, video_mode_e mode,
	int ha, int hf, int hs, int hb, int va, int vf, int vs, int vb, logic neg, bit vert);
	entry_t e;
	e.name    = name;
	e.code    = code;
	e.mode    = mode;
	e.h_total = ha + hf + hs + hb; // Full line over all four regions
	e.h_sw    = hs;
	e.h_act   = ha;
	e.v_total = va + vf + vs + vb;
	e.v_act   = va;
	e.neg     = neg;
	e.vert    = vert;
	return e;
endfunction

task automatic load_table();
	tbl[0] = make_entry("vga", `VTC_SW_VGA, MODE_VGA, `VTC_VGA_HACT, `VTC_VGA_HFP,
		`VTC_VGA_HSW, `VTC_VGA_HBP, `VTC_VGA_VACT, `VTC_VGA_VFP, `VTC_VGA_VSW,
		`VTC_VGA_VBP, `VTC_VGA_NEG, 1'b1);
	tbl[1] = make_entry("svga", `VTC_SW_SVGA, MODE_SVGA, `VTC_SVGA_HACT, `VTC_SVGA_HFP,
		`VTC_SVGA_HSW, `VTC_SVGA_HBP, `VTC_SVGA_VACT, `VTC_SVGA_VFP, `VTC_SVGA_VSW,
		`VTC_SVGA_VBP, `VTC_SVGA_NEG, 1'b1);
	tbl[2] = make_entry("xga", `VTC_SW_XGA, MODE_XGA, `VTC_XGA_HACT, `VTC_XGA_HFP,
		`VTC_XGA_HSW, `VTC_XGA_HBP, `VTC_XGA_VACT, `VTC_XGA_VFP, `VTC_XGA_VSW,
		`VTC_XGA_VBP, `VTC_XGA_NEG, 1'b0);
	// Unknown code falls back to 720p
	tbl[3] = make_entry("unknown 0101", 4'b0101, MODE_HD720, `VTC_HD720_HACT,
		`VTC_HD720_HFP, `VTC_HD720_HSW, `VTC_HD720_HBP, `VTC_HD720_VACT, `VTC_HD720_VFP,
		`VTC_HD720_VSW, `VTC_HD720_VBP, `VTC_HD720_NEG, 1'b0);
	tbl[4] = make_entry("sxga", `VTC_SW_SXGA, MODE_SXGA, `VTC_SXGA_HACT, `VTC_SXGA_HFP,
		`VTC_SXGA_HSW, `VTC_SXGA_HBP, `VTC_SXGA_VACT, `VTC_SXGA_VFP, `VTC_SXGA_VSW,
		`VTC_SXGA_VBP, `VTC_SXGA_NEG, 1'b0);
	tbl[5] = make_entry("hd720", `VTC_SW_HD720, MODE_HD720, `VTC_HD720_HACT,
		`VTC_HD720_HFP, `VTC_HD720_HSW, `VTC_HD720_HBP, `VTC_HD720_VACT, `VTC_HD720_VFP,
		`VTC_HD720_VSW, `VTC_HD720_VBP, `VTC_HD720_NEG, 1'b0);
	tbl[6] = make_entry("camera", `VTC_SW_CAMERA, MODE_CAMERA, `VTC_CAMERA_HACT,
		`VTC_CAMERA_HFP, `VTC_CAMERA_HSW, `VTC_CAMERA_HBP, `VTC_CAMERA_VACT,
		`VTC_CAMERA_VFP, `VTC_CAMERA_VSW, `VTC_CAMERA_VBP, `VTC_CAMERA_NEG, 1'b0);
	tbl[7] = make_entry("unknown 1111", 4'b1111, MODE_HD720, `VTC_HD720_HACT,
		`VTC_HD720_HFP, `VTC_HD720_HSW, `VTC_HD720_HBP, `VTC_HD720_VACT, `VTC_HD720_VFP,
		`VTC_HD720_VSW, `VTC_HD720_VBP, `VTC_HD720_NEG, 1'b0);
endtask

// Cycle budget for the whole run
function automatic int unsigned run_budget();
	int unsigned sum;
	sum = 0;
	for (int i = 0; i < 8; i++) begin
		sum += 5 * tbl[i].h_total + `VTC_DEBOUNCE_CYCLES + 8; // Settle, skip 2, measure 1
		if (tbl[i].vert) begin
			sum += 2 * tbl[i].h_total * tbl[i].v_total; // Find vsync, then a full frame
		end
	end
	sum += 3 * 2048; // Closing tests take a line each at most
	return 2 * sum + 24 * (`VTC_DEBOUNCE_CYCLES + 16);
endfunction

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw_bits(input int n, output int v);
	v = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = (v << 1) | lfsr_state[0];
	end
endtask

// Switch value seen for n rising edges
task automatic hold_sw(input sw_code_t v, input int n);
	@(posedge clk50m_bufg);
	#1 sw = v;
	repeat (n - 1) @(posedge clk50m_bufg);
endtask

task automatic compare(input string what, input int got, input int exp);
	if (got != exp) begin
		errors++;
		$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic end_test(input string name, input int base);
	if (errors == base) begin
		passed++;
		$display("test %s: pass", name);
	end else begin
		failed++;
		$display("test %s: FAIL, %0d mismatches", name, errors - base);
	end
endtask

// Counters must have run on from (h0, v0) without a restart
task automatic check_free_run(input string tag, input entry_t e, input int h0, input int v0,
	input int unsigned c0);
	int pos;
	pos = v0 * e.h_total + h0 + int'(cycles - c0);
	compare({"hcount after ", tag}, hcount, pos % e.h_total);
	compare({"vcount after ", tag}, vcount, (pos / e.h_total) % e.v_total);
endtask

////////////////////////////////////////////////////////////////////////////
// Measurement sampled on the falling edge
////////////////////////////////////////////////////////////////////////////
task automatic wait_hsync_edge(input logic act);
	logic prev;
	prev = hsync;
	forever begin
		@(negedge clk50m_bufg);
		if (hsync == act && prev != act) break;
		prev = hsync;
	end
endtask

// One hsync edge to the next
task automatic measure_line(input logic act, output int period, output int width,
	output int de_cnt, output logic idle);
	bit gone;
	wait_hsync_edge(act);
	period = 0;
	width  = 0;
	de_cnt = 0;
	gone   = 1'b0;
	idle   = act;
	forever begin
		if (!gone && hsync != act) begin
			gone = 1'b1;
		end
		if (!gone) width++;
		if (de) begin
			if (de_cnt == 0) idle = hsync; // Level during active video
			de_cnt++;
		end
		period++;
		@(negedge clk50m_bufg);
		if (gone && hsync == act) break;
	end
endtask

// One vsync edge to the next with lines counted on hsync edges
task automatic measure_frame(input logic act, output int lines, output int de_lines);
	logic hprev;
	logic vprev;
	logic had_de;
	vprev = vsync;
	forever begin
		@(negedge clk50m_bufg);
		if (vsync == act && vprev != act) break;
		vprev = vsync;
	end
	lines    = 0;
	de_lines = 0;
	had_de   = 1'b0;
	hprev    = hsync;
	vprev    = vsync;
	forever begin
		@(negedge clk50m_bufg);
		if (hsync == act && hprev != act) begin
			lines++;
			if (had_de) de_lines++;
			had_de = 1'b0;
		end
		if (de) had_de = 1'b1;
		if (vsync == act && vprev != act) break;
		hprev = hsync;
		vprev = vsync;
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Sequence
////////////////////////////////////////////////////////////////////////////
initial begin
	entry_t      e;
	int          period;
	int          width;
	int          de_cnt;
	int          lines;
	int          de_lines;
	int          mask;
	int          len;
	int          base;
	int          h0;
	int          v0;
	int unsigned c0;
	logic        idle;

	RSTBTN = 1'b1;
	sw     = `VTC_SW_VGA;
	load_table();
	limit = run_budget();
	repeat (3) @(posedge clk50m_bufg);
	#1 RSTBTN = 1'b0;

	// State right out of reset with VGA idle syncs high
	base = errors;
	@(negedge clk50m_bufg);
	compare("active_mode", active_mode, MODE_VGA);
	compare("de", de, 0);
	compare("hsync", hsync, `VTC_VGA_NEG);
	compare("vsync", vsync, `VTC_VGA_NEG);
	end_test("reset state", base);

	foreach (tbl[i]) begin
		e    = tbl[i];
		base = errors;
		hold_sw(e.code, 1);
		while (active_mode != e.mode) @(negedge clk50m_bufg);
		wait_hsync_edge(!e.neg); // Two lines to flush the restart
		wait_hsync_edge(!e.neg);
		measure_line(!e.neg, period, width, de_cnt, idle);
		compare({e.name, " line length"}, period, e.h_total);
		compare({e.name, " hsync width"}, width, e.h_sw);
		compare({e.name, " de per line"}, de_cnt, e.h_act);
		compare({e.name, " hsync idle"}, idle, e.neg);
		if (e.vert) begin
			measure_frame(!e.neg, lines, de_lines);
			compare({e.name, " frame lines"}, lines, e.v_total);
			compare({e.name, " active lines"}, de_lines, e.v_act);
		end
		end_test(e.name, base);
	end

	// Short bounces around VGA, then a held SXGA code
	base = errors;
	hold_sw(`VTC_SW_VGA, 1);
	while (active_mode != MODE_VGA) @(negedge clk50m_bufg);
	repeat (4) @(negedge clk50m_bufg);
	h0 = hcount;
	v0 = vcount;
	c0 = cycles;
	for (int k = 0; k < 8; k++) begin
		draw_bits(4, mask);
		if (mask == 0) mask = 1;
		draw_bits(4, len);
		hold_sw(`VTC_SW_VGA ^ sw_code_t'(mask), 1 + len % (`VTC_DEBOUNCE_CYCLES - 1)); // Under the limit
		draw_bits(3, len);
		hold_sw(`VTC_SW_VGA, 1 + len);
	end
	repeat (`VTC_DEBOUNCE_CYCLES + 8) @(negedge clk50m_bufg);
	compare("active_mode after bounce", active_mode, MODE_VGA);
	check_free_run("bounce", tbl[0], h0, v0, c0);
	hold_sw(`VTC_SW_SXGA, 1);
	while (active_mode != MODE_SXGA) @(negedge clk50m_bufg);
	end_test("debounce", base);

	// Glitch and return to the code in use without a restart
	base = errors;
	repeat (4) @(negedge clk50m_bufg);
	h0 = hcount;
	v0 = vcount;
	c0 = cycles;
	hold_sw(`VTC_SW_VGA, 3);
	hold_sw(`VTC_SW_SXGA, 40);
	@(negedge clk50m_bufg);
	compare("active_mode after repeat", active_mode, MODE_SXGA);
	check_free_run("repeat", tbl[4], h0, v0, c0);
	end_test("repeated code", base);

	if (u_vtc_top.u_props.fail_count != 0) begin
		$display("%0d property assertions failed inside the DUT", u_vtc_top.u_props.fail_count);
		failed++;
	end
	$display("tests passed %0d, failed %0d", passed, failed);
	if (failed == 0) begin
		$display("Test completed successfully");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/vtc_pkg.sv
mode_ctrl/switch_conditioner.sv
mode_ctrl/mode_decoder.sv
rtl/raster_timing.sv
rtl/vtc_top.sv
verif/vtc_properties.sv
verif/tb_vtc.sv

// File: Bender.yml
package:
  name: vtc

sources:
  - include_dirs:
      - common
    files:
      - common/vtc_pkg.sv
      - mode_ctrl/switch_conditioner.sv
      - mode_ctrl/mode_decoder.sv
      - rtl/raster_timing.sv
      - rtl/vtc_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/vtc_properties.sv
      - verif/tb_vtc.sv
